// File: rv_core.f
rv_core_pkg.sv
core_ctrl_if.sv
alu.sv
register_file.sv
control_fsm.sv
datapath.sv
rv_core_top.sv
tb_checker.sv
tb_rv_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rv_core
RTL_TOP  = rv_core_top
FILELIST = rv_core.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_rv_core.sv
/*
 * Testbench for the multicycle core. The memory model answers each
 * start 1 to 4 cycles later and ignores strobes during reset.
 * The program image sits at address 0 and ends in a halt loop.
 */
`timescale 1ns/100ps

module tb_rv_core
    import rv_core_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 200 * 14 * 2;

    logic            i_clk;
    logic            i_rst;
    logic [XLEN-1:0] i_mem_rdata;
    logic            i_mem_done;
    logic [XLEN-1:0] o_mem_addr;
    logic [XLEN-1:0] o_mem_wdata;
    logic            o_mem_read;
    logic            o_mem_write;
    logic [31:0]     mem [0:1023];
    logic [31:0]     image [0:1023];
    logic            done;
    int              mismatches;
    int              failures;
    int              checked;
    int              cycle_count;
    int              wp;
    int              so;

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        image[wp[9:0]] = word;
        wp++;
    endtask

    // Stores a register to the next slot above x2.
    task automatic store_reg(input logic [4:0] rs);
        logic [11:0] off;
        off = so[11:0];
        emit({off[11:5], rs, 5'd2, 3'b011, off[4:0], OP_STORE});
        so += 8;
    endtask

    task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3);
        emit(enc_r(f7, 5'd4, 5'd3, f3, 5'd5));
        store_reg(5'd5);
    endtask

    task automatic alu_i(input logic [11:0] imm, input logic [2:0] f3);
        emit(enc_i(imm, 5'd3, f3, 5'd5, OP_I));
        store_reg(5'd5);
    endtask

    rv_core_top rv_core_top_i (
        .i_clk       ( i_clk       ),
        .i_rst       ( i_rst       ),
        .i_mem_rdata ( i_mem_rdata ),
        .i_mem_done  ( i_mem_done  ),
        .o_mem_addr  ( o_mem_addr  ),
        .o_mem_wdata ( o_mem_wdata ),
        .o_mem_read  ( o_mem_read  ),
        .o_mem_write ( o_mem_write )
    );

    tb_checker tb_checker_i (
        .i_clk        ( i_clk       ),
        .i_rst        ( i_rst       ),
        .i_mem_addr   ( o_mem_addr  ),
        .i_mem_wdata  ( o_mem_wdata ),
        .i_mem_read   ( o_mem_read  ),
        .i_mem_write  ( o_mem_write ),
        .i_image      ( image       ),
        .o_done       ( done        ),
        .o_mismatches ( mismatches  ),
        .o_failures   ( failures    ),
        .o_checked    ( checked     )
    );

    initial begin
        i_clk = 1'b0;
    end

    always #5 i_clk = ~i_clk;

    initial begin
        cycle_count = 0;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ----------------------------------------------------------
    // Memory model with random latency.
    // ----------------------------------------------------------
    initial begin
        logic [9:0]      idx;
        logic            is_write;
        logic [XLEN-1:0] wdata;
        int              lat;
        forever begin
            @(negedge i_clk);
            if (!i_rst && (o_mem_read || o_mem_write)) begin
                idx      = o_mem_addr[11:2];
                is_write = o_mem_write;
                wdata    = o_mem_wdata;
                lat      = 1 + int'($urandom % 4);
                repeat (lat) @(posedge i_clk);
                #1;
                if (is_write) begin
                    mem[idx]         = wdata[31:0];
                    mem[idx + 10'd1] = wdata[63:32];
                end
                i_mem_rdata = {mem[idx + 10'd1], mem[idx]};
                i_mem_done  = 1'b1;
                @(posedge i_clk);
                #1;
                i_mem_done = 1'b0;
            end
        end
    end

    initial begin
        logic timed_out;
        void'($urandom(21));
        i_rst       = 1'b1;
        i_mem_done  = 1'b0;
        i_mem_rdata = '0;
        timed_out   = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            image[i[9:0]] = $urandom;
        end
        wp = 0;
        so = 0;
        // Bases: random data at 0x400, results at 0x600.
        emit(enc_i(12'h400, 5'd0, 3'b000, 5'd1, OP_I));
        emit(enc_i(12'h600, 5'd0, 3'b000, 5'd2, OP_I));
        emit(enc_i(12'd0, 5'd1, 3'b011, 5'd3, OP_LOAD));
        emit(enc_i(12'd8, 5'd1, 3'b011, 5'd4, OP_LOAD));
        store_reg(5'd3);
        alu_r(7'h00, 3'd0);
        alu_r(7'h20, 3'd0);
        alu_r(7'h00, 3'd7);
        alu_r(7'h00, 3'd6);
        alu_r(7'h00, 3'd4);
        alu_r(7'h00, 3'd1);
        alu_r(7'h00, 3'd5);
        alu_r(7'h20, 3'd5);
        alu_r(7'h00, 3'd2);
        alu_r(7'h00, 3'd3);
        alu_i(12'hffb, 3'd0);
        alu_i(12'h5a3, 3'd4);
        alu_i(12'h0f0, 3'd6);
        alu_i(12'h8ff, 3'd7);
        alu_i(12'h00d, 3'd1);
        alu_i(12'h009, 3'd5);
        alu_i(12'h407, 3'd5);
        alu_i(12'h123, 3'd2);
        alu_i(12'hfff, 3'd3);
        emit({20'habcde, 5'd6, OP_LUI});
        store_reg(5'd6);
        // Writes to x0 vanish.
        emit(enc_i(12'd5, 5'd3, 3'b000, 5'd0, OP_I));
        emit(enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd0));
        store_reg(5'd0);
        // Taken beq, untaken bne, data-dependent bne.
        emit(enc_b(13'd8, 5'd3, 5'd3, 3'b000));
        emit(enc_i(12'd77, 5'd0, 3'b000, 5'd9, OP_I));
        emit(enc_b(13'd8, 5'd3, 5'd3, 3'b001));
        emit(enc_i(12'd3, 5'd9, 3'b000, 5'd9, OP_I));
        store_reg(5'd9);
        emit(enc_b(13'd8, 5'd4, 5'd3, 3'b001));
        emit(enc_i(12'd100, 5'd9, 3'b000, 5'd9, OP_I));
        store_reg(5'd9);
        emit(enc_j(21'd8, 5'd8));
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd9, OP_I));
        store_reg(5'd8);
        store_reg(5'd9);
        // Counted loop with a backward bne.
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd10, OP_I));
        emit(enc_i(12'hfff, 5'd10, 3'b000, 5'd10, OP_I));
        emit(enc_r(7'h00, 5'd10, 5'd11, 3'd0, 5'd11));
        emit(enc_b(13'h1ff8, 5'd0, 5'd10, 3'b001));
        store_reg(5'd11);
        emit(enc_j(21'd0, 5'd0));
        for (int i = 0; i < 1024; i++) begin
            mem[i[9:0]] = image[i[9:0]];
        end
        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        while (!done && cycle_count < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
        end
        if (!done) begin
            $display("Timeout: the core did not reach the halt loop in %0d cycles",
                     TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end
        $display("Run finished: %0d instructions, %0d mismatches, %0d other errors",
                 checked, mismatches, failures + (timed_out ? 1 : 0));
        if (mismatches == 0 && failures == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb_checker.sv
/*
 * Reference instruction-set model of the core and the comparing
 * process. Strobes are sampled on the falling clock edge. The model
 * memory is copied from the image while reset is high. Memory is
 * 1024 words of 32 bits, so addresses wrap at 4 KB.
 */
`timescale 1ns/100ps

module tb_checker
    import rv_core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_mem_addr,
    input  logic [XLEN-1:0] i_mem_wdata,
    input  logic            i_mem_read,
    input  logic            i_mem_write,
    input  logic [31:0]     i_image [0:1023],
    output logic            o_done,
    output int              o_mismatches,
    output int              o_failures,
    output int              o_checked
);

    localparam logic [31:0] HALT_INSTR = 32'h0000006f;
    localparam int KIND_NONE  = 0;
    localparam int KIND_LOAD  = 1;
    localparam int KIND_STORE = 2;

    logic [XLEN-1:0] m_pc;
    logic [XLEN-1:0] m_regs [0:NUM_REGS-1];
    logic [31:0]     m_mem [0:1023];
    int              exp_kind;
    logic [XLEN-1:0] exp_addr;
    logic [XLEN-1:0] exp_data;

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic bit30,
                                                input logic is_r, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'd0:    return (is_r && bit30) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3:    return (a < b) ? 64'd1 : 64'd0;
            3'd4:    return a ^ b;
            3'd5:    return bit30 ? XLEN'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ----------------------------------------------------------
    // Steps the model by one instruction.
    // ----------------------------------------------------------
    function automatic void step_model(output int kind, output logic [XLEN-1:0] addr,
                                       output logic [XLEN-1:0] data);
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] next_pc;
        logic [9:0]      idx;
        logic            wr;
        instr   = m_mem[m_pc[11:2]];
        rd      = instr[11:7];
        a       = m_regs[instr[19:15]];
        b       = m_regs[instr[24:20]];
        imm_i   = {{52{instr[31]}}, instr[31:20]};
        next_pc = m_pc + 64'd4;
        res     = '0;
        wr      = 1'b0;
        kind    = KIND_NONE;
        addr    = '0;
        data    = '0;
        case (instr[6:0])
            OP_R: begin
                res = alu_ref(instr[14:12], instr[30], 1'b1, a, b);
                wr  = 1'b1;
            end
            OP_I: begin
                res = alu_ref(instr[14:12], instr[30], 1'b0, a, imm_i);
                wr  = 1'b1;
            end
            OP_LOAD: begin
                kind = KIND_LOAD;
                addr = a + imm_i;
                idx  = addr[11:2];
                res  = {m_mem[idx + 10'd1], m_mem[idx]};
                wr   = 1'b1;
            end
            OP_STORE: begin
                kind = KIND_STORE;
                addr = a + {{52{instr[31]}}, instr[31:25], instr[11:7]};
                data = b;
                idx  = addr[11:2];
                m_mem[idx]         = b[31:0];
                m_mem[idx + 10'd1] = b[63:32];
            end
            OP_BRANCH: begin
                if ((instr[14:12] == 3'd0) == (a == b)) begin
                    next_pc = m_pc + {{51{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
                end
            end
            OP_JAL: begin
                res     = m_pc + 64'd4;
                wr      = 1'b1;
                next_pc = m_pc + {{43{instr[31]}}, instr[31], instr[19:12],
                                  instr[20], instr[30:21], 1'b0};
            end
            OP_LUI: begin
                res = {{32{instr[31]}}, instr[31:12], 12'b0};
                wr  = 1'b1;
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        if (wr && rd != 5'd0) begin
            m_regs[rd] = res;
        end
        m_pc = next_pc;
    endfunction

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            o_mismatches++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        o_failures++;
    endtask

    initial begin
        o_done       = 1'b0;
        o_mismatches = 0;
        o_failures   = 0;
        o_checked    = 0;
        exp_kind     = KIND_NONE;
    end

    always @(negedge i_clk) begin
        if (i_rst) begin
            if (i_mem_read || i_mem_write) begin
                report_failure("a memory strobe was high during reset");
            end
            for (int i = 0; i < 1024; i++) begin
                m_mem[i[9:0]] = i_image[i[9:0]];
            end
            for (int r = 0; r < NUM_REGS; r++) begin
                m_regs[r[4:0]] = '0;
            end
            m_pc     = '0;
            exp_kind = KIND_NONE;
            o_done   = 1'b0;
        end else if (!o_done && (i_mem_read || i_mem_write)) begin
            if (exp_kind == KIND_STORE) begin
                if (!i_mem_write) begin
                    report_failure("a read started where a store was expected");
                end
                report_mismatch("o_mem_addr", exp_addr, i_mem_addr);
                report_mismatch("o_mem_wdata", exp_data, i_mem_wdata);
                exp_kind = KIND_NONE;
            end else if (exp_kind == KIND_LOAD) begin
                if (!i_mem_read) begin
                    report_failure("a write started where a load was expected");
                end
                report_mismatch("o_mem_addr", exp_addr, i_mem_addr);
                exp_kind = KIND_NONE;
            end else begin
                // Fetch.
                if (i_mem_write) begin
                    report_failure("a write started where a fetch was expected");
                end
                report_mismatch("o_mem_addr", m_pc, i_mem_addr);
                if (m_mem[m_pc[11:2]] == HALT_INSTR) begin
                    o_done = 1'b1;
                end else begin
                    step_model(exp_kind, exp_addr, exp_data);
                    o_checked++;
                end
            end
        end
    end

endmodule

// File: rv_core_top.sv
/*
 * Multicycle RV64 core with a single memory port shared by fetch
 * and data. A start strobe lasts one cycle, address and write data
 * hold until i_mem_done, and read data is taken in the done cycle.
 */
`timescale 1ns/100ps

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_mem_rdata,
    input  logic            i_mem_done,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    output logic            o_mem_read,
    output logic            o_mem_write
);

    core_ctrl_if core_ctrl_if_i ();

    control_fsm control_fsm_i (
        .i_clk       ( i_clk               ),
        .i_rst       ( i_rst               ),
        .i_mem_done  ( i_mem_done          ),
        .o_mem_read  ( o_mem_read          ),
        .o_mem_write ( o_mem_write         ),
        .ctrl_if     ( core_ctrl_if_i.ctrl )
    );

    datapath datapath_i (
        .i_clk       ( i_clk             ),
        .i_rst       ( i_rst             ),
        .i_mem_rdata ( i_mem_rdata       ),
        .o_mem_addr  ( o_mem_addr        ),
        .o_mem_wdata ( o_mem_wdata       ),
        .ctrl_if     ( core_ctrl_if_i.dp )
    );

endmodule

// File: datapath.sv
/*
 * Multicycle datapath around one shared memory port.
 * Every access is a doubleword, and addresses are not checked for
 * alignment. The data address register follows the result while the
 * port is on the PC and holds during a data transfer.
 */
`timescale 1ns/100ps

module datapath
    import rv_core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_mem_rdata,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    core_ctrl_if.dp         ctrl_if
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] old_pc;
    logic [ILEN-1:0] instr;
    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_now;
    logic [XLEN-1:0] alu_reg;
    logic [XLEN-1:0] mem_data;
    logic [XLEN-1:0] data_addr;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] result;

    assign ctrl_if.opcode      = instr[6:0];
    assign ctrl_if.funct3      = instr[14:12];
    assign ctrl_if.funct7_bit5 = instr[30];

    // ----------------------------------------------------------
    // Architectural and holding registers.
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc    <= '0;
            instr <= '0;
        end else begin
            if (ctrl_if.pc_we) begin
                pc <= result;
            end
            if (ctrl_if.instr_we) begin
                instr <= i_mem_rdata[ILEN-1:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        rs1_data <= rf_rdata1;
        rs2_data <= rf_rdata2;
        alu_reg  <= alu_now;
        if (ctrl_if.instr_we) begin
            old_pc <= pc;
        end
        if (ctrl_if.mem_data_we) begin
            mem_data <= i_mem_rdata;
        end
        if (ctrl_if.addr_src == ADDR_PC) begin
            data_addr <= result;
        end
    end

    // Immediate extension.
    always_comb begin
        case (ctrl_if.imm_type)
            IMM_I:   imm_ext = {{(XLEN-12){instr[31]}}, instr[31:20]};
            IMM_S:   imm_ext = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm_ext = {{(XLEN-13){instr[31]}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};
            IMM_J:   imm_ext = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};
            IMM_U:   imm_ext = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            default: imm_ext = '0;
        endcase
    end

    // Operand and result selection.
    always_comb begin
        case (ctrl_if.alu_src_a)
            SRC_A_PC:     src_a = pc;
            SRC_A_OLD_PC: src_a = old_pc;
            default:      src_a = rs1_data;
        endcase
        case (ctrl_if.alu_src_b)
            SRC_B_RS2: src_b = rs2_data;
            SRC_B_IMM: src_b = imm_ext;
            default:   src_b = XLEN'(4);
        endcase
        case (ctrl_if.result_src)
            RES_ALU_REG:  result = alu_reg;
            RES_MEM_DATA: result = mem_data;
            RES_ALU_NOW:  result = alu_now;
            default:      result = imm_ext;
        endcase
    end

    assign o_mem_addr  = (ctrl_if.addr_src == ADDR_DATA) ? data_addr : pc;
    assign o_mem_wdata = rs2_data;

    register_file register_file_i (
        .i_clk    ( i_clk          ),
        .i_rst    ( i_rst          ),
        .i_we     ( ctrl_if.reg_we ),
        .i_rs1    ( instr[19:15]   ),
        .i_rs2    ( instr[24:20]   ),
        .i_rd     ( instr[11:7]    ),
        .i_wdata  ( result         ),
        .o_rdata1 ( rf_rdata1      ),
        .o_rdata2 ( rf_rdata2      )
    );

    alu alu_i (
        .i_op     ( ctrl_if.alu_op    ),
        .i_a      ( src_a             ),
        .i_b      ( src_b             ),
        .o_result ( alu_now           ),
        .o_zero   ( ctrl_if.zero_flag )
    );

    // B and J targets are only halfword multiples, and nothing traps them.
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        pc[1:0] == 2'b00);

endmodule

// File: control_fsm.sv
/*
 * Multicycle sequencer: fetch, decode, execute, memory, writeback.
 * The memory strobes are state decodes and stay low while i_rst
 * holds the FSM in FETCH. Unknown opcodes retire after EXECUTE.
 */
`timescale 1ns/100ps

module control_fsm
    import rv_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_mem_done,
    output logic      o_mem_read,
    output logic      o_mem_write,
    core_ctrl_if.ctrl ctrl_if
);

    typedef enum logic [2:0] {
        S_FETCH, S_FETCH_WAIT, S_DECODE, S_EXECUTE, S_MEM, S_MEM_WAIT, S_WRITEBACK
    } state_e;

    state_e    state;
    state_e    state_next;
    imm_type_e imm_sel;
    alu_op_e   op_decoded;
    logic      is_load;
    logic      take_branch;
    logic      pending;

    function automatic alu_op_e decode_alu_op(input logic [6:0] opcode,
                                              input logic [2:0] funct3,
                                              input logic       f7_bit5);
        case (funct3)
            // Only R-type uses bit 30 to pick sub.
            F3_ADD_SUB: return (opcode == OP_R && f7_bit5) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return f7_bit5 ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign op_decoded  = decode_alu_op(ctrl_if.opcode, ctrl_if.funct3, ctrl_if.funct7_bit5);
    assign is_load     = (ctrl_if.opcode == OP_LOAD);
    // Beq takes on a zero difference, bne on a nonzero one.
    assign take_branch = (ctrl_if.zero_flag == (ctrl_if.funct3 == F3_BEQ));

    always_comb begin
        case (ctrl_if.opcode)
            OP_STORE:  imm_sel = IMM_S;
            OP_BRANCH: imm_sel = IMM_B;
            OP_JAL:    imm_sel = IMM_J;
            OP_LUI:    imm_sel = IMM_U;
            default:   imm_sel = IMM_I;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------------------------
    // Per-state selects and enables.
    // ----------------------------------------------------------
    always_comb begin
        state_next          = state;
        o_mem_read          = 1'b0;
        o_mem_write         = 1'b0;
        ctrl_if.alu_op      = ALU_ADD;
        ctrl_if.imm_type    = imm_sel;
        ctrl_if.alu_src_a   = SRC_A_PC;
        ctrl_if.alu_src_b   = SRC_B_FOUR;
        ctrl_if.result_src  = RES_ALU_REG;
        ctrl_if.addr_src    = ADDR_PC;
        ctrl_if.reg_we      = 1'b0;
        ctrl_if.pc_we       = 1'b0;
        ctrl_if.instr_we    = 1'b0;
        ctrl_if.mem_data_we = 1'b0;
        case (state)
            S_FETCH: begin
                // No start while reset holds the FSM here.
                o_mem_read = !i_rst;
                state_next = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
                // PC + 4 goes straight from the ALU into the PC.
                ctrl_if.result_src = RES_ALU_NOW;
                if (i_mem_done) begin
                    ctrl_if.instr_we = 1'b1;
                    ctrl_if.pc_we    = 1'b1;
                    state_next       = S_DECODE;
                end
            end
            S_DECODE: begin
                // Branch or jump target lands in the ALU result register.
                ctrl_if.alu_src_a = SRC_A_OLD_PC;
                ctrl_if.alu_src_b = SRC_B_IMM;
                state_next        = S_EXECUTE;
            end
            S_EXECUTE: begin
                ctrl_if.alu_src_a = SRC_A_RS1;
                ctrl_if.alu_src_b = SRC_B_IMM;
                state_next        = S_WRITEBACK;
                case (ctrl_if.opcode)
                    OP_R: begin
                        ctrl_if.alu_src_b = SRC_B_RS2;
                        ctrl_if.alu_op    = op_decoded;
                    end
                    OP_I: begin
                        ctrl_if.alu_op = op_decoded;
                    end
                    OP_LOAD, OP_STORE: begin
                        ctrl_if.result_src = RES_ALU_NOW;
                        state_next         = S_MEM;
                    end
                    OP_BRANCH: begin
                        ctrl_if.alu_src_b = SRC_B_RS2;
                        ctrl_if.alu_op    = ALU_SUB;
                        ctrl_if.pc_we     = take_branch;
                        state_next        = S_FETCH;
                    end
                    OP_JAL: begin
                        // Link value old_pc + 4 is computed as the PC jumps.
                        ctrl_if.alu_src_a = SRC_A_OLD_PC;
                        ctrl_if.alu_src_b = SRC_B_FOUR;
                        ctrl_if.pc_we     = 1'b1;
                    end
                    OP_LUI: begin
                        state_next = S_WRITEBACK;
                    end
                    default: begin
                        state_next = S_FETCH;
                    end
                endcase
            end
            S_MEM: begin
                ctrl_if.addr_src = ADDR_DATA;
                o_mem_read       = is_load;
                o_mem_write      = !is_load;
                state_next       = S_MEM_WAIT;
            end
            S_MEM_WAIT: begin
                ctrl_if.addr_src = ADDR_DATA;
                if (i_mem_done) begin
                    ctrl_if.mem_data_we = is_load;
                    state_next          = is_load ? S_WRITEBACK : S_FETCH;
                end
            end
            S_WRITEBACK: begin
                ctrl_if.reg_we = 1'b1;
                if (is_load) begin
                    ctrl_if.result_src = RES_MEM_DATA;
                end else if (ctrl_if.opcode == OP_LUI) begin
                    ctrl_if.result_src = RES_IMM;
                end
                state_next = S_FETCH;
            end
            default: begin
                state_next = S_FETCH;
            end
        endcase
    end

    // Outstanding transfer, from start to done.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending <= 1'b0;
        end else if (o_mem_read || o_mem_write) begin
            pending <= 1'b1;
        end else if (i_mem_done) begin
            pending <= 1'b0;
        end
    end

    a_one_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_mem_read && o_mem_write));

    a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_mem_read || o_mem_write) |-> !pending);

endmodule

// File: register_file.sv
/*
 * Integer register file, two asynchronous reads and one write.
 * x0 is not stored and always reads zero.
 */
`timescale 1ns/100ps

module register_file
    import rv_core_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_wdata,
    output logic [XLEN-1:0]       o_rdata1,
    output logic [XLEN-1:0]       o_rdata2
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Index zero never reaches the array.
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: alu.sv
/*
 * 64-bit integer ALU, purely combinational.
 * Shifts use the low 6 bits of the second operand.
 */
`timescale 1ns/100ps

module alu
    import rv_core_pkg::*;
(
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result,
    output logic            o_zero
);

    logic [5:0] shamt;

    assign shamt = i_b[5:0];

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = $signed(i_a) >>> shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
            default:  o_result = '0;
        endcase
    end

    // Branches compare with sub.
    assign o_zero = (o_result == '0);

endmodule

// File: core_ctrl_if.sv
/*
 * Control and status bundle between the control FSM and the datapath.
 * All members are level signals valid within the current cycle.
 */
`timescale 1ns/100ps

interface core_ctrl_if
    import rv_core_pkg::*;
();

    // Selects and enables from the FSM.
    alu_op_e     alu_op;
    imm_type_e   imm_type;
    alu_src_a_e  alu_src_a;
    alu_src_b_e  alu_src_b;
    result_src_e result_src;
    addr_src_e   addr_src;
    logic        reg_we;
    logic        pc_we;
    logic        instr_we;
    logic        mem_data_we;

    // Instruction fields and the ALU flag, back to the FSM.
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7_bit5;
    logic        zero_flag;

    modport ctrl (
        output alu_op, imm_type, alu_src_a, alu_src_b, result_src, addr_src,
        output reg_we, pc_we, instr_we, mem_data_we,
        input  opcode, funct3, funct7_bit5, zero_flag
    );

    modport dp (
        input  alu_op, imm_type, alu_src_a, alu_src_b, result_src, addr_src,
        input  reg_we, pc_we, instr_we, mem_data_we,
        output opcode, funct3, funct7_bit5, zero_flag
    );

endinterface

// File: rv_core_pkg.sv
/*
 * Widths, opcodes and control select encodings for the multicycle
 * RV64 core. Only the opcodes of the supported subset are listed.
 * Any other opcode passes through the core as a no-op.
 */
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Base opcodes.
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // Funct3 of the ALU operations and of the two branches.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_BEQ     = 3'b000;

    // ----------------------------------------------------------
    // Control selects.
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_type_e;

    typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1} alu_src_a_e;

    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} alu_src_b_e;

    // Registered ALU result, load data, live ALU output, immediate.
    typedef enum logic [1:0] {RES_ALU_REG, RES_MEM_DATA, RES_ALU_NOW, RES_IMM} result_src_e;

    typedef enum logic {ADDR_PC, ADDR_DATA} addr_src_e;

endpackage
